//--- fpu_ss_defines.svh
`ifndef FPU_SS_DEFINES_SVH
`define FPU_SS_DEFINES_SVH

// number of private fp registers
`define FPU_SS_NUM_FPR 32

// --------------------
// major opcodes
// --------------------
`define FPU_SS_OPC_LOAD_FP  7'b0000111
`define FPU_SS_OPC_STORE_FP 7'b0100111
`define FPU_SS_OPC_OP_FP    7'b1010011

// funct7 of the supported op-fp forms
`define FPU_SS_F7_SGNJ   7'b0010000
`define FPU_SS_F7_FMV_XW 7'b1110000

// funct3 values
`define FPU_SS_F3_SGNJ  3'b000
`define FPU_SS_F3_SGNJN 3'b001
`define FPU_SS_F3_SGNJX 3'b010
`define FPU_SS_F3_FMV   3'b000
// word width for flw and fsw
`define FPU_SS_F3_W     3'b010

// axi response code
`define FPU_SS_AXI_OKAY 2'b00

`endif

//--- fpu_ss_pkg.sv
`default_nettype none

package fpu_ss_pkg;

  // --------------------
  // widths
  // --------------------
  typedef logic [31:0] word_t;
  typedef logic [4:0]  fpr_addr_t;
  typedef logic [3:0]  instr_id_t;
  typedef logic [1:0]  axi_resp_t;

  // sign-injection unit operations
  typedef enum logic [1:0] {
    SGNJ,
    SGNJN,
    SGNJX,
    MV_XW
  } sgnj_op_e;

  // load/store fsm
  typedef enum logic [2:0] {
    IDLE,
    AR,
    R,
    AW_W,
    B
  } lsu_state_e;

  // --------------------
  // channel payloads
  // --------------------
  // offloaded instruction from the core
  typedef struct packed {
    word_t     instr;
    word_t     rs1;
    instr_id_t id;
  } issue_req_t;

  typedef struct packed {
    sgnj_op_e  op;
    word_t     a;
    word_t     b;
    fpr_addr_t rd;
    instr_id_t id;
  } sgnj_cmd_t;

  typedef struct packed {
    logic      is_store;
    word_t     addr;
    word_t     wdata;
    fpr_addr_t rd;
    instr_id_t id;
  } lsu_cmd_t;

  // result offer of one unit
  typedef struct packed {
    logic      fpr_we;
    fpr_addr_t rd;
    word_t     data;
    instr_id_t id;
    logic      err;
  } wb_req_t;

  // we is the integer rd write
  typedef struct packed {
    instr_id_t id;
    word_t     data;
    logic      we;
    logic      err;
  } result_t;

  // axi4-lite payloads
  typedef struct packed {
    word_t addr;
  } axi_aw_t;

  typedef struct packed {
    word_t      data;
    logic [3:0] strb;
  } axi_w_t;

  typedef struct packed {
    word_t addr;
  } axi_ar_t;

  typedef struct packed {
    word_t     rdata;
    axi_resp_t resp;
  } axi_r_t;

endpackage

`default_nettype wire

//--- fpu_ss_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_ss_defines.svh"

module fpu_ss_regfile
  import fpu_ss_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  // two read ports, operand a and b
  input  wire fpr_addr_t raddr_a_i,
  input  wire fpr_addr_t raddr_b_i,
  output word_t          rdata_a_o,
  output word_t          rdata_b_o,
  // single write port from the arbiter
  input  wire logic      we_i,
  input  wire fpr_addr_t waddr_i,
  input  wire word_t     wdata_i
);

  word_t regs [`FPU_SS_NUM_FPR];

  // all registers read zero after reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `FPU_SS_NUM_FPR; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // old value seen in the write cycle
  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

endmodule

`default_nettype wire

//--- fpu_ss_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_ss_defines.svh"

module fpu_ss_issue
  import fpu_ss_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_i,
  // issue port
  input  wire logic       issue_valid_i,
  input  wire issue_req_t issue_req_i,
  output logic            issue_ready_o,
  output logic            issue_accept_o,
  // register file reads
  output fpr_addr_t       raddr_a_o,
  output fpr_addr_t       raddr_b_o,
  input  wire word_t      rdata_a_i,
  input  wire word_t      rdata_b_i,
  // command channels
  output logic            sgnj_valid_o,
  output sgnj_cmd_t       sgnj_cmd_o,
  input  wire logic       sgnj_ready_i,
  output logic            lsu_valid_o,
  output lsu_cmd_t        lsu_cmd_o,
  input  wire logic       lsu_ready_i,
  // fp write-back retire
  input  wire logic       retire_i,
  input  wire fpr_addr_t  retire_rd_i
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  fpr_addr_t  rd;
  fpr_addr_t  rs1;
  fpr_addr_t  rs2;
  logic       is_load;
  logic       is_store;
  logic       is_sgnj;
  logic       is_fmv;
  logic       unit_ready;
  logic       hazard;
  logic       fire;
  word_t      imm;
  sgnj_op_e   op;
  // issue enable, raised once out of reset
  logic       run_q;
  // one pending fp destination per unit
  logic       sgnj_pend_q;
  fpr_addr_t  sgnj_pend_rd_q;
  logic       lsu_pend_q;
  fpr_addr_t  lsu_pend_rd_q;

  // in-flight writer to the given register
  function automatic logic pend_hit(input fpr_addr_t r);
    return (sgnj_pend_q && sgnj_pend_rd_q == r) || (lsu_pend_q && lsu_pend_rd_q == r);
  endfunction

  // --------------------
  // decode
  // --------------------
  assign opcode = issue_req_i.instr[6:0];
  assign rd     = issue_req_i.instr[11:7];
  assign funct3 = issue_req_i.instr[14:12];
  assign rs1    = issue_req_i.instr[19:15];
  assign rs2    = issue_req_i.instr[24:20];
  assign funct7 = issue_req_i.instr[31:25];

  assign is_load  = opcode == `FPU_SS_OPC_LOAD_FP && funct3 == `FPU_SS_F3_W;
  assign is_store = opcode == `FPU_SS_OPC_STORE_FP && funct3 == `FPU_SS_F3_W;
  assign is_sgnj  = opcode == `FPU_SS_OPC_OP_FP && funct7 == `FPU_SS_F7_SGNJ &&
                    (funct3 == `FPU_SS_F3_SGNJ || funct3 == `FPU_SS_F3_SGNJN ||
                     funct3 == `FPU_SS_F3_SGNJX);
  // fmv.x.w needs rs2 zero
  assign is_fmv   = opcode == `FPU_SS_OPC_OP_FP && funct7 == `FPU_SS_F7_FMV_XW &&
                    funct3 == `FPU_SS_F3_FMV && rs2 == '0;

  assign issue_accept_o = is_load | is_store | is_sgnj | is_fmv;

  always_comb begin
    op = MV_XW;
    if (is_sgnj) begin
      case (funct3)
        `FPU_SS_F3_SGNJN: op = SGNJN;
        `FPU_SS_F3_SGNJX: op = SGNJX;
        default:          op = SGNJ;
      endcase
    end
  end

  // sign-extended s or i immediate
  assign imm = is_store ? {{20{funct7[6]}}, funct7, rd} : {{20{funct7[6]}}, funct7, rs2};

  // --------------------
  // hazards and ready
  // --------------------
  // sources a=rs1 (sgnj, fmv), b=rs2 (sgnj, fsw), dest rd (sgnj, flw)
  assign hazard = ((is_sgnj | is_fmv) && pend_hit(rs1)) ||
                  ((is_sgnj | is_store) && pend_hit(rs2)) ||
                  ((is_sgnj | is_load) && pend_hit(rd));

  assign unit_ready = (is_load | is_store) ? lsu_ready_i : sgnj_ready_i;

  // rejected instructions complete their handshake right away
  assign issue_ready_o = run_q & (~issue_accept_o | (unit_ready & ~hazard));
  assign fire          = issue_valid_i & issue_ready_o & issue_accept_o;

  // --------------------
  // dispatch
  // --------------------
  assign raddr_a_o = rs1;
  assign raddr_b_o = rs2;

  assign sgnj_valid_o  = fire & (is_sgnj | is_fmv);
  assign sgnj_cmd_o.op = op;
  assign sgnj_cmd_o.a  = rdata_a_i;
  assign sgnj_cmd_o.b  = rdata_b_i;
  assign sgnj_cmd_o.rd = rd;
  assign sgnj_cmd_o.id = issue_req_i.id;

  assign lsu_valid_o        = fire & (is_load | is_store);
  assign lsu_cmd_o.is_store = is_store;
  assign lsu_cmd_o.addr     = issue_req_i.rs1 + imm;
  assign lsu_cmd_o.wdata    = rdata_b_i;
  assign lsu_cmd_o.rd       = rd;
  assign lsu_cmd_o.id       = issue_req_i.id;

  // set at dispatch, cleared on retire of a matching rd
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      run_q       <= 1'b0;
      sgnj_pend_q <= 1'b0;
      lsu_pend_q  <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (retire_i && sgnj_pend_rd_q == retire_rd_i) begin
        sgnj_pend_q <= 1'b0;
      end
      if (retire_i && lsu_pend_rd_q == retire_rd_i) begin
        lsu_pend_q <= 1'b0;
      end
      // fmv.x.w and fsw write no fp register
      if (sgnj_valid_o && is_sgnj) begin
        sgnj_pend_q <= 1'b1;
      end
      if (lsu_valid_o && is_load) begin
        lsu_pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sgnj_valid_o) begin
      sgnj_pend_rd_q <= rd;
    end
    if (lsu_valid_o) begin
      lsu_pend_rd_q <= rd;
    end
  end

endmodule

`default_nettype wire

//--- fpu_ss_sgnj_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ss_sgnj_unit
  import fpu_ss_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  // command from issue
  input  wire logic      cmd_valid_i,
  input  wire sgnj_cmd_t cmd_i,
  output logic           cmd_ready_o,
  // offer to the arbiter
  output logic           wb_valid_o,
  output wb_req_t        wb_o,
  input  wire logic      done_i
);

  logic    wb_valid_q;
  wb_req_t wb_q;
  word_t   res;

  // magnitude from a, sign by operation
  always_comb begin
    case (cmd_i.op)
      SGNJ:    res = {cmd_i.b[31], cmd_i.a[30:0]};
      SGNJN:   res = {~cmd_i.b[31], cmd_i.a[30:0]};
      SGNJX:   res = {cmd_i.a[31] ^ cmd_i.b[31], cmd_i.a[30:0]};
      default: res = cmd_i.a;
    endcase
  end

  // idle while no offer is held
  assign cmd_ready_o = ~wb_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_valid_q <= 1'b0;
    end else if (cmd_valid_i && cmd_ready_o) begin
      wb_valid_q <= 1'b1;
    end else if (done_i) begin
      wb_valid_q <= 1'b0;
    end
  end

  // result held until the arbiter takes it
  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && cmd_ready_o) begin
      // fmv.x.w goes to the integer side only
      wb_q.fpr_we <= cmd_i.op != MV_XW;
      wb_q.rd     <= cmd_i.rd;
      wb_q.data   <= res;
      wb_q.id     <= cmd_i.id;
      wb_q.err    <= 1'b0;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_o       = wb_q;

endmodule

`default_nettype wire

//--- fpu_ss_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_ss_defines.svh"

module fpu_ss_lsu
  import fpu_ss_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  // command from issue
  input  wire logic      cmd_valid_i,
  input  wire lsu_cmd_t  cmd_i,
  output logic           cmd_ready_o,
  // offer to the arbiter
  output logic           wb_valid_o,
  output wb_req_t        wb_o,
  input  wire logic      done_i,
  // axi4-lite master
  output logic           axi_awvalid_o,
  input  wire logic      axi_awready_i,
  output axi_aw_t        axi_aw_o,
  output logic           axi_wvalid_o,
  input  wire logic      axi_wready_i,
  output axi_w_t         axi_w_o,
  input  wire logic      axi_bvalid_i,
  output logic           axi_bready_o,
  input  wire axi_resp_t axi_bresp_i,
  output logic           axi_arvalid_o,
  input  wire logic      axi_arready_i,
  output axi_ar_t        axi_ar_o,
  input  wire logic      axi_rvalid_i,
  output logic           axi_rready_o,
  input  wire axi_r_t    axi_r_i
);

  lsu_state_e state_q;
  // aw and w still owed in AW_W
  logic       aw_pend_q;
  logic       w_pend_q;
  logic       wb_valid_q;
  wb_req_t    wb_q;
  word_t      addr_q;
  word_t      wdata_q;
  logic       aw_hs;
  logic       w_hs;

  assign cmd_ready_o = state_q == IDLE && ~wb_valid_q;

  // --------------------
  // axi channels
  // --------------------
  assign axi_arvalid_o = state_q == AR;
  assign axi_rready_o  = state_q == R;
  assign axi_awvalid_o = state_q == AW_W && aw_pend_q;
  assign axi_wvalid_o  = state_q == AW_W && w_pend_q;
  assign axi_bready_o  = state_q == B;

  assign axi_ar_o.addr = addr_q;
  assign axi_aw_o.addr = addr_q;
  // full word stores only
  assign axi_w_o.data  = wdata_q;
  assign axi_w_o.strb  = 4'hf;

  assign aw_hs = axi_awvalid_o & axi_awready_i;
  assign w_hs  = axi_wvalid_o & axi_wready_i;

  // --------------------
  // fsm
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      aw_pend_q  <= 1'b0;
      w_pend_q   <= 1'b0;
      wb_valid_q <= 1'b0;
    end else begin
      if (done_i) begin
        wb_valid_q <= 1'b0;
      end
      case (state_q)
        IDLE: begin
          if (cmd_valid_i && cmd_ready_o) begin
            state_q   <= cmd_i.is_store ? AW_W : AR;
            aw_pend_q <= cmd_i.is_store;
            w_pend_q  <= cmd_i.is_store;
          end
        end
        AR: begin
          if (axi_arready_i) begin
            state_q <= R;
          end
        end
        R: begin
          if (axi_rvalid_i) begin
            state_q    <= IDLE;
            wb_valid_q <= 1'b1;
          end
        end
        AW_W: begin
          if (aw_hs) begin
            aw_pend_q <= 1'b0;
          end
          if (w_hs) begin
            w_pend_q <= 1'b0;
          end
          // both channels done, this cycle or earlier
          if ((~aw_pend_q | aw_hs) && (~w_pend_q | w_hs)) begin
            state_q <= B;
          end
        end
        B: begin
          if (axi_bvalid_i) begin
            state_q    <= IDLE;
            wb_valid_q <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // request and offer payload
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && cmd_valid_i && cmd_ready_o) begin
      addr_q  <= cmd_i.addr;
      wdata_q <= cmd_i.wdata;
      wb_q.rd <= cmd_i.rd;
      wb_q.id <= cmd_i.id;
    end
    if (state_q == R && axi_rvalid_i) begin
      // failed load leaves rd untouched
      wb_q.fpr_we <= axi_r_i.resp == `FPU_SS_AXI_OKAY;
      wb_q.data   <= axi_r_i.rdata;
      wb_q.err    <= axi_r_i.resp != `FPU_SS_AXI_OKAY;
    end
    if (state_q == B && axi_bvalid_i) begin
      wb_q.fpr_we <= 1'b0;
      wb_q.data   <= '0;
      wb_q.err    <= axi_bresp_i != `FPU_SS_AXI_OKAY;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_o       = wb_q;

endmodule

`default_nettype wire

//--- fpu_ss_wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ss_wb_arbiter
  import fpu_ss_pkg::*;
(
  // unit offers
  input  wire logic    lsu_valid_i,
  input  wire wb_req_t lsu_wb_i,
  output logic         lsu_done_o,
  input  wire logic    sgnj_valid_i,
  input  wire wb_req_t sgnj_wb_i,
  output logic         sgnj_done_o,
  // fp register write port
  output logic         fpr_we_o,
  output fpr_addr_t    fpr_waddr_o,
  output word_t        fpr_wdata_o,
  // result port
  output logic         result_valid_o,
  input  wire logic    result_ready_i,
  output result_t      result_o,
  // retire to issue
  output logic         retire_o,
  output fpr_addr_t    retire_rd_o
);

  wb_req_t win;
  logic    fire;
  logic    int_we;

  // load/store unit has priority
  assign win = lsu_valid_i ? lsu_wb_i : sgnj_wb_i;

  assign result_valid_o = lsu_valid_i | sgnj_valid_i;
  assign fire           = result_valid_o & result_ready_i;

  // done releases the winning offer
  assign lsu_done_o  = fire & lsu_valid_i;
  assign sgnj_done_o = fire & ~lsu_valid_i;

  // integer rd write only for fmv.x.w
  assign int_we = sgnj_valid_i & ~lsu_valid_i & ~sgnj_wb_i.fpr_we;

  assign result_o.id   = win.id;
  // data only goes back with an integer write
  assign result_o.data = int_we ? win.data : '0;
  assign result_o.we   = int_we;
  assign result_o.err  = win.err;

  // register write once, on the result handshake
  assign fpr_we_o    = fire & win.fpr_we;
  assign fpr_waddr_o = win.rd;
  assign fpr_wdata_o = win.data;

  assign retire_o    = fpr_we_o;
  assign retire_rd_o = win.rd;

endmodule

`default_nettype wire

//--- fpu_ss_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ss_top
  import fpu_ss_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_i,
  // issue port
  input  wire logic       issue_valid_i,
  input  wire issue_req_t issue_req_i,
  output logic            issue_ready_o,
  output logic            issue_accept_o,
  // result port
  output logic            result_valid_o,
  input  wire logic       result_ready_i,
  output result_t         result_o,
  // axi4-lite master
  output logic            axi_awvalid_o,
  input  wire logic       axi_awready_i,
  output axi_aw_t         axi_aw_o,
  output logic            axi_wvalid_o,
  input  wire logic       axi_wready_i,
  output axi_w_t          axi_w_o,
  input  wire logic       axi_bvalid_i,
  output logic            axi_bready_o,
  input  wire axi_resp_t  axi_bresp_i,
  output logic            axi_arvalid_o,
  input  wire logic       axi_arready_i,
  output axi_ar_t         axi_ar_o,
  input  wire logic       axi_rvalid_i,
  output logic            axi_rready_o,
  input  wire axi_r_t     axi_r_i
);

  // register file reads
  fpr_addr_t raddr_a;
  fpr_addr_t raddr_b;
  word_t     rdata_a;
  word_t     rdata_b;
  // command channels
  logic      sgnj_valid;
  logic      sgnj_ready;
  sgnj_cmd_t sgnj_cmd;
  logic      lsu_valid;
  logic      lsu_ready;
  lsu_cmd_t  lsu_cmd;
  // unit offers
  logic      sgnj_wb_valid;
  wb_req_t   sgnj_wb;
  logic      sgnj_done;
  logic      lsu_wb_valid;
  wb_req_t   lsu_wb;
  logic      lsu_done;
  // write-back
  logic      fpr_we;
  fpr_addr_t fpr_waddr;
  word_t     fpr_wdata;
  logic      retire;
  fpr_addr_t retire_rd;

  // --------------------
  // front end
  // --------------------
  fpu_ss_issue fpu_ss_issue_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .issue_valid_i  (issue_valid_i),
    .issue_req_i    (issue_req_i),
    .issue_ready_o  (issue_ready_o),
    .issue_accept_o (issue_accept_o),
    .raddr_a_o      (raddr_a),
    .raddr_b_o      (raddr_b),
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b),
    .sgnj_valid_o   (sgnj_valid),
    .sgnj_cmd_o     (sgnj_cmd),
    .sgnj_ready_i   (sgnj_ready),
    .lsu_valid_o    (lsu_valid),
    .lsu_cmd_o      (lsu_cmd),
    .lsu_ready_i    (lsu_ready),
    .retire_i       (retire),
    .retire_rd_i    (retire_rd)
  );

  fpu_ss_regfile fpu_ss_regfile_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (fpr_we),
    .waddr_i   (fpr_waddr),
    .wdata_i   (fpr_wdata)
  );

  // --------------------
  // execution units
  // --------------------
  fpu_ss_sgnj_unit fpu_ss_sgnj_unit_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (sgnj_valid),
    .cmd_i       (sgnj_cmd),
    .cmd_ready_o (sgnj_ready),
    .wb_valid_o  (sgnj_wb_valid),
    .wb_o        (sgnj_wb),
    .done_i      (sgnj_done)
  );

  fpu_ss_lsu fpu_ss_lsu_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_valid_i   (lsu_valid),
    .cmd_i         (lsu_cmd),
    .cmd_ready_o   (lsu_ready),
    .wb_valid_o    (lsu_wb_valid),
    .wb_o          (lsu_wb),
    .done_i        (lsu_done),
    .axi_awvalid_o (axi_awvalid_o),
    .axi_awready_i (axi_awready_i),
    .axi_aw_o      (axi_aw_o),
    .axi_wvalid_o  (axi_wvalid_o),
    .axi_wready_i  (axi_wready_i),
    .axi_w_o       (axi_w_o),
    .axi_bvalid_i  (axi_bvalid_i),
    .axi_bready_o  (axi_bready_o),
    .axi_bresp_i   (axi_bresp_i),
    .axi_arvalid_o (axi_arvalid_o),
    .axi_arready_i (axi_arready_i),
    .axi_ar_o      (axi_ar_o),
    .axi_rvalid_i  (axi_rvalid_i),
    .axi_rready_o  (axi_rready_o),
    .axi_r_i       (axi_r_i)
  );

  // shared write port and result port
  fpu_ss_wb_arbiter fpu_ss_wb_arbiter_inst (
    .lsu_valid_i    (lsu_wb_valid),
    .lsu_wb_i       (lsu_wb),
    .lsu_done_o     (lsu_done),
    .sgnj_valid_i   (sgnj_wb_valid),
    .sgnj_wb_i      (sgnj_wb),
    .sgnj_done_o    (sgnj_done),
    .fpr_we_o       (fpr_we),
    .fpr_waddr_o    (fpr_waddr),
    .fpr_wdata_o    (fpr_wdata),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .retire_o       (retire),
    .retire_rd_o    (retire_rd)
  );

endmodule

`default_nettype wire

//--- fpu_ss_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ss_asserts
  import fpu_ss_pkg::*;
(
  input wire logic    clk_i,
  input wire logic    rst_i,
  input wire logic    result_valid_i,
  input wire logic    result_ready_i,
  input wire logic    arvalid_i,
  input wire logic    arready_i,
  input wire axi_ar_t ar_i,
  input wire logic    awvalid_i,
  input wire logic    awready_i,
  input wire axi_aw_t aw_i,
  input wire logic    wvalid_i,
  input wire logic    wready_i,
  input wire axi_w_t  w_i,
  input wire logic    fpr_we_i
);

  // --------------------
  // handshake rules
  // --------------------
  result_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    result_valid_i && !result_ready_i |=> result_valid_i)
    else $error("result valid dropped before ready");

  ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
    else $error("ar channel changed before handshake");

  aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    awvalid_i && !awready_i |=> awvalid_i && $stable(aw_i))
    else $error("aw channel changed before handshake");

  w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    wvalid_i && !wready_i |=> wvalid_i && $stable(w_i))
    else $error("w channel changed before handshake");

  // register file quiet in reset
  no_reset_write: assert property (@(posedge clk_i) rst_i |-> !fpr_we_i)
    else $error("register write during reset");

endmodule

bind fpu_ss_top fpu_ss_asserts fpu_ss_asserts_inst (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .result_valid_i (result_valid_o),
  .result_ready_i (result_ready_i),
  .arvalid_i      (axi_arvalid_o),
  .arready_i      (axi_arready_i),
  .ar_i           (axi_ar_o),
  .awvalid_i      (axi_awvalid_o),
  .awready_i      (axi_awready_i),
  .aw_i           (axi_aw_o),
  .wvalid_i       (axi_wvalid_o),
  .wready_i       (axi_wready_i),
  .w_i            (axi_w_o),
  .fpr_we_i       (fpr_we)
);

`default_nettype wire

//--- tb_fpu_ss.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_ss_defines.svh"

module tb_fpu_ss
  import fpu_ss_pkg::*;
();

  localparam int TIMEOUT = 200;

  // one expected memory access
  typedef struct packed {
    logic      is_store;
    word_t     addr;
    word_t     wdata;
    word_t     rdata;
    axi_resp_t resp;
  } mem_op_t;

  logic       clk_i;
  logic       rst_i;
  logic       issue_valid_i;
  issue_req_t issue_req_i;
  logic       issue_ready_o;
  logic       issue_accept_o;
  logic       result_valid_o;
  logic       result_ready_i;
  result_t    result_o;
  logic       axi_awvalid_o;
  logic       axi_awready_i;
  axi_aw_t    axi_aw_o;
  logic       axi_wvalid_o;
  logic       axi_wready_i;
  axi_w_t     axi_w_o;
  logic       axi_bvalid_i;
  logic       axi_bready_o;
  axi_resp_t  axi_bresp_i;
  logic       axi_arvalid_o;
  logic       axi_arready_i;
  axi_ar_t    axi_ar_o;
  logic       axi_rvalid_i;
  logic       axi_rready_o;
  axi_r_t     axi_r_i;

  // expected results by id
  result_t    exp_res [16];
  logic       exp_busy [16];
  int         outstanding;
  mem_op_t    mem_ops [$];
  word_t      mem [16];
  word_t      lcg_state;

  fpu_ss_top fpu_ss_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------
  // helpers
  // --------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    end
  endtask

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // byte address dependent fill
  function automatic word_t mem_fill(input int idx);
    logic [15:0] a;
    a = 16'(idx * 4);
    return {a ^ 16'h5a5a, a};
  endfunction

  // rs1 plus the i or s immediate
  function automatic word_t mem_addr(input word_t instr, input word_t rs1);
    word_t imm;
    if (instr[6:0] == `FPU_SS_OPC_STORE_FP) begin
      imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    end else begin
      imm = {{20{instr[31]}}, instr[31:20]};
    end
    return rs1 + imm;
  endfunction

  // --------------------
  // issue driver
  // --------------------
  task automatic issue_instr(input word_t instr, input word_t rs1, input instr_id_t id,
                             input logic acc, input word_t rdata, input axi_resp_t resp,
                             input word_t data, input logic we, input logic err);
    int      cnt;
    logic    is_mem;
    logic    is_st;
    mem_op_t op;
    cnt = 0;
    is_st  = instr[6:0] == `FPU_SS_OPC_STORE_FP;
    is_mem = is_st || instr[6:0] == `FPU_SS_OPC_LOAD_FP;
    issue_valid_i     = 1'b1;
    issue_req_i.instr = instr;
    issue_req_i.rs1   = rs1;
    issue_req_i.id    = id;
    @(negedge clk_i);
    while (!issue_ready_o) begin
      cnt++;
      if (cnt > TIMEOUT) abort_run($sformatf("issue of %h never became ready", instr));
      @(negedge clk_i);
    end
    check_value("issue_accept_o", 32'(issue_accept_o), 32'(acc));
    if (acc) begin
      if (exp_busy[id]) abort_run("instruction id reused while still in flight");
      exp_busy[id]     = 1'b1;
      // stores and loads return no data
      exp_res[id].id   = id;
      exp_res[id].data = is_st ? '0 : data;
      exp_res[id].we   = we;
      exp_res[id].err  = err;
      outstanding++;
      if (is_mem) begin
        op.is_store = is_st;
        op.addr     = mem_addr(instr, rs1);
        op.wdata    = data;
        op.rdata    = rdata;
        op.resp     = resp;
        mem_ops.push_back(op);
      end
    end
    @(posedge clk_i);
    #1;
    issue_valid_i = 1'b0;
  endtask

  // --------------------
  // result monitor
  // --------------------
  initial begin
    forever begin
      @(negedge clk_i);
      if (!rst_i && result_valid_o && result_ready_i) begin
        if (!exp_busy[result_o.id]) begin
          abort_run($sformatf("result with id %h matches no instruction", result_o.id));
        end
        check_value("result_o.data", result_o.data, exp_res[result_o.id].data);
        check_value("result_o.we", 32'(result_o.we), 32'(exp_res[result_o.id].we));
        check_value("result_o.err", 32'(result_o.err), 32'(exp_res[result_o.id].err));
        exp_busy[result_o.id] = 1'b0;
        outstanding--;
      end
    end
  end

  // random result back-pressure about one cycle in four
  initial begin
    logic out_of_reset;
    forever begin
      @(posedge clk_i);
      out_of_reset = !rst_i;
      #1;
      if (out_of_reset) result_ready_i = lcg_next() >> 16 & 32'h3 ? 1'b1 : 1'b0;
    end
  end

  // --------------------
  // axi4-lite memory model
  // --------------------
  task automatic serve_read();
    mem_op_t op;
    int      cnt;
    cnt = 0;
    if (mem_ops.size() == 0) abort_run("read request with no load outstanding");
    op = mem_ops.pop_front();
    if (op.is_store) abort_run("read request where a store was expected");
    check_value("axi_ar_o.addr", axi_ar_o.addr, op.addr);
    // one wait state before the address is taken
    @(posedge clk_i);
    #1;
    axi_arready_i = 1'b1;
    @(posedge clk_i);
    #1;
    axi_arready_i = 1'b0;
    axi_rvalid_i  = 1'b1;
    axi_r_i.rdata = op.rdata;
    axi_r_i.resp  = op.resp;
    @(negedge clk_i);
    while (!axi_rready_o) begin
      cnt++;
      if (cnt > TIMEOUT) abort_run("read data never accepted");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    axi_rvalid_i = 1'b0;
  endtask

  task automatic serve_write();
    mem_op_t op;
    logic    got_aw;
    logic    got_w;
    word_t   addr;
    axi_w_t  wr;
    int      cnt;
    got_aw = 1'b0;
    got_w  = 1'b0;
    cnt    = 0;
    while (!(got_aw && got_w)) begin
      if (axi_awvalid_o) begin
        got_aw = 1'b1;
        addr   = axi_aw_o.addr;
      end
      if (axi_wvalid_o) begin
        got_w = 1'b1;
        wr    = axi_w_o;
      end
      if (!(got_aw && got_w)) begin
        cnt++;
        if (cnt > TIMEOUT) abort_run("write address or data never arrived");
        @(negedge clk_i);
      end
    end
    if (mem_ops.size() == 0) abort_run("write request with no store outstanding");
    op = mem_ops.pop_front();
    if (!op.is_store) abort_run("write request where a load was expected");
    check_value("axi_aw_o.addr", addr, op.addr);
    check_value("axi_w_o.data", wr.data, op.wdata);
    check_value("axi_w_o.strb", 32'(wr.strb), 32'hf);
    if (op.resp == `FPU_SS_AXI_OKAY) begin
      mem[addr[5:2]] = wr.data;
    end
    // w taken one cycle ahead of aw
    @(posedge clk_i);
    #1;
    axi_wready_i = 1'b1;
    @(posedge clk_i);
    #1;
    axi_wready_i  = 1'b0;
    axi_awready_i = 1'b1;
    @(posedge clk_i);
    #1;
    axi_awready_i = 1'b0;
    axi_bvalid_i  = 1'b1;
    axi_bresp_i   = op.resp;
    cnt = 0;
    @(negedge clk_i);
    while (!axi_bready_o) begin
      cnt++;
      if (cnt > TIMEOUT) abort_run("write response never accepted");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    axi_bvalid_i = 1'b0;
  endtask

  initial begin
    forever begin
      @(negedge clk_i);
      if (!rst_i && axi_arvalid_o) begin
        serve_read();
      end else if (!rst_i && (axi_awvalid_o || axi_wvalid_o)) begin
        serve_write();
      end
    end
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int        fd;
    int        n;
    int        code;
    int        cnt;
    string     line;
    word_t     instr;
    word_t     rs1;
    instr_id_t id;
    logic      acc;
    word_t     rdata;
    axi_resp_t resp;
    word_t     data;
    logic      we;
    logic      err;
    rst_i          = 1'b1;
    issue_valid_i  = 1'b0;
    issue_req_i    = '0;
    result_ready_i = 1'b0;
    axi_awready_i  = 1'b0;
    axi_wready_i   = 1'b0;
    axi_bvalid_i   = 1'b0;
    axi_bresp_i    = '0;
    axi_arready_i  = 1'b0;
    axi_rvalid_i   = 1'b0;
    axi_r_i        = '0;
    lcg_state      = 32'h5710_2023;
    outstanding    = 0;
    for (int i = 0; i < 16; i++) begin
      exp_busy[i] = 1'b0;
      exp_res[i]  = '0;
      mem[i]      = mem_fill(i);
    end
    fd = $fopen("fpu_ss_trace.txt", "r");
    if (fd == 0) abort_run("cannot open fpu_ss_trace.txt");
    @(posedge clk_i);
    #1;
    // ready raised inside reset to expose stray register writes
    result_ready_i = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                  instr, rs1, id, acc, rdata, resp, data, we, err);
      // header and blank lines do not parse
      if (code > 0 && n == 9) begin
        issue_instr(instr, rs1, id, acc, rdata, resp, data, we, err);
      end
    end
    $fclose(fd);
    cnt = 0;
    while (outstanding != 0) begin
      cnt++;
      if (cnt > TIMEOUT) abort_run("results still missing at the end of the trace");
      @(negedge clk_i);
    end
    // stray results would show here
    repeat (10) @(negedge clk_i);
    // failed store left its word alone
    check_value("mem[1]", mem[1], mem_fill(1));
    check_value("mem[8]", mem[8], 32'h40490fdb);
    if (outstanding == 0 && mem_ops.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      abort_run("unconsumed results or memory accesses remain");
    end
  end

endmodule

`default_nettype wire

//--- fpu_ss_trace.txt
# instr rs1 id accept rdata resp data we err (all hex)
# data is the result data, or for fsw the word expected on the write channel
0000A087 00000010 0 1 3F800000 0 00000000 0 0
0040A107 00000010 1 1 C0490FDB 0 00000000 0 0
E00082D3 00000000 2 1 00000000 0 3F800000 1 0
202081D3 00000000 3 1 00000000 0 00000000 0 0
20211253 00000000 4 1 00000000 0 00000000 0 0
2021A2D3 00000000 5 1 00000000 0 00000000 0 0
E0018353 00000000 6 1 00000000 0 BF800000 1 0
E00203D3 00000000 7 1 00000000 0 40490FDB 1 0
E0028453 00000000 8 1 00000000 0 3F800000 1 0
FE412C27 00000028 9 1 00000000 0 40490FDB 0 0
0000A087 00000030 A 1 DEADBEEF 2 00000000 0 1
0020A027 00000004 B 1 00000000 2 C0490FDB 0 1
E00082D3 00000000 C 1 00000000 0 3F800000 1 0
002081B3 00000000 D 0 00000000 0 00000000 0 0
F00000D3 00000000 E 0 00000000 0 00000000 0 0
0080A307 00000000 F 1 12345678 0 00000000 0 0
205203D3 00000000 0 1 00000000 0 00000000 0 0
E00304D3 00000000 1 1 00000000 0 12345678 1 0
E0038553 00000000 2 1 00000000 0 40490FDB 1 0

//--- files.f
+incdir+.
fpu_ss_pkg.sv
fpu_ss_regfile.sv
fpu_ss_issue.sv
fpu_ss_sgnj_unit.sv
fpu_ss_lsu.sv
fpu_ss_wb_arbiter.sv
fpu_ss_top.sv
fpu_ss_asserts.sv
tb_fpu_ss.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_fpu_ss -Mdir obj_dir -f files.f
	./obj_dir/Vtb_fpu_ss | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
